// ==== verification/response_fabric_cases.txt ====
# Columns: command letter, then hex fields (W takes a decimal cycle count)
# R mask tag data | A mask tag status | Y ready_mask | W cycles | F read_full ack_full | E name
R 1 11 a0a0a001
W 8
E single_read
A 4 22 2
W 8
E single_ack
R f 33 12345678
A a 34 3
R 0 35 deadbeef
A 0 36 1
W 10
E broadcast_and_zero_mask
R 3 40 00000040
A 6 41 1
R c 42 00000042
A 9 43 2
R f 44 00000044
A f 45 3
R 5 46 00000046
A 3 47 0
W 12
E mixed_order
Y b
A 4 50 0
A 4 51 1
A 4 52 2
A 4 53 3
A 4 54 0
A 4 55 1
A 4 56 2
A 4 57 3
W 2
F 0 1
Y f
W 20
F 0 0
E stalled_lane

// ==== build.f ====
source/response_pkg.sv
source/response_fifo.sv
source/response_distributor.sv
source/response_merger.sv
source/response_fabric_top.sv
verification/response_fabric_assert.sv
verification/response_fabric_tb.sv

// ==== Bender.yml ====
package:
  name: response_fabric

sources:
  - source/response_pkg.sv
  - source/response_fifo.sv
  - source/response_distributor.sv
  - source/response_merger.sv
  - source/response_fabric_top.sv
  - target: test
    files:
      - verification/response_fabric_assert.sv
      - verification/response_fabric_tb.sv

// ==== verification/response_fabric_tb.sv ====
// Testbench for the response path; replays the cases file and checks every lane's responses
module response_fabric_tb
  import response_pkg::*;
();

  logic                    ap_clk;
  logic                    areset_control;
  logic                    read_valid;
  lane_mask_t              read_mask;
  logic [tag_width-1:0]    read_tag;
  logic [data_width-1:0]   read_data;
  logic                    ack_valid;
  lane_mask_t              ack_mask;
  logic [tag_width-1:0]    ack_tag;
  logic [status_width-1:0] ack_status;
  lane_mask_t              response_ready;
  lane_mask_t              response_valid;
  lane_mask_t              response_is_ack;
  logic [tag_width-1:0]    response_tag    [num_lanes];
  logic [data_width-1:0]   response_data   [num_lanes];
  logic [status_width-1:0] response_status [num_lanes];
  logic                    read_full;
  logic                    ack_full;
  logic                    setup_busy;

  // Expected items per lane and per kind in send order
  read_payload_t read_q [num_lanes][$];
  ack_payload_t  ack_q  [num_lanes][$];
  string         case_lines[$];
  int            error_count = 0;
  int            test_start_errors = 0;
  int            test_count = 0;
  int            failed_tests = 0;
  int            cycle_count = 0;
  int            cycle_limit = 200;

  response_fabric_top u_response_fabric_top (.*);

  initial begin
    ap_clk = 1'b0;
    forever #20 ap_clk = ~ap_clk;
  end

  // Run limit scaled from the number of case lines
  always @(posedge ap_clk) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("Timeout after %0d cycles, the cases did not run to their end", cycle_limit);
      $display("Testbench failed");
      $finish;
    end
  end

  // --------------------
  // Helpers
  // --------------------
  task automatic tick();
    @(posedge ap_clk);
    #5;
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("FAILED time %0t %s expected %h got %h", $time, name, expected, actual);
    error_count++;
  endtask

  task automatic report_problem(input string text);
    $display("%s", text);
    error_count++;
  endtask

  function automatic int pending_items();
    int total = 0;
    for (int lane = 0; lane < num_lanes; lane++) begin
      total += read_q[lane].size() + ack_q[lane].size();
    end
    return total;
  endfunction

  task automatic send_read(input lane_mask_t mask, input logic [tag_width-1:0] tag,
                           input logic [data_width-1:0] data);
    read_payload_t item;
    item.tag   = tag;
    item.data  = data;
    read_valid = 1'b1;
    read_mask  = mask;
    read_tag   = tag;
    read_data  = data;
    for (int lane = 0; lane < num_lanes; lane++) begin
      if (mask[lane]) read_q[lane].push_back(item);
    end
    tick();
    read_valid = 1'b0;
  endtask

  task automatic send_ack(input lane_mask_t mask, input logic [tag_width-1:0] tag,
                          input logic [status_width-1:0] status);
    ack_payload_t item;
    item.tag    = tag;
    item.status = status;
    ack_valid   = 1'b1;
    ack_mask    = mask;
    ack_tag     = tag;
    ack_status  = status;
    for (int lane = 0; lane < num_lanes; lane++) begin
      if (mask[lane]) ack_q[lane].push_back(item);
    end
    tick();
    ack_valid = 1'b0;
  endtask

  // --------------------
  // Output checking
  // --------------------
  task automatic check_lane(input int lane);
    read_payload_t exp_read;
    ack_payload_t  exp_ack;
    if (response_is_ack[lane]) begin
      if (ack_q[lane].size() == 0) begin
        report_problem($sformatf("Lane %0d delivered an ack with tag %h that nobody sent",
                                 lane, response_tag[lane]));
      end else begin
        exp_ack = ack_q[lane].pop_front();
        assert (response_tag[lane] == exp_ack.tag) else
          report_mismatch($sformatf("response_tag[%0d]", lane), exp_ack.tag, response_tag[lane]);
        assert (response_status[lane] == exp_ack.status) else
          report_mismatch($sformatf("response_status[%0d]", lane), exp_ack.status,
                          response_status[lane]);
        assert (response_data[lane] == '0) else
          report_mismatch($sformatf("response_data[%0d]", lane), 0, response_data[lane]);
      end
    end else begin
      if (read_q[lane].size() == 0) begin
        report_problem($sformatf("Lane %0d delivered a read with tag %h that nobody sent",
                                 lane, response_tag[lane]));
      end else begin
        exp_read = read_q[lane].pop_front();
        assert (response_tag[lane] == exp_read.tag) else
          report_mismatch($sformatf("response_tag[%0d]", lane), exp_read.tag, response_tag[lane]);
        assert (response_data[lane] == exp_read.data) else
          report_mismatch($sformatf("response_data[%0d]", lane), exp_read.data,
                          response_data[lane]);
        assert (response_status[lane] == '0) else
          report_mismatch($sformatf("response_status[%0d]", lane), 0, response_status[lane]);
      end
    end
  endtask

  // Outputs change on the rising edge and are sampled on the falling one
  always @(negedge ap_clk) begin
    if (!areset_control) begin
      for (int lane = 0; lane < num_lanes; lane++) begin
        if (response_valid[lane]) check_lane(lane);
      end
    end
  end

  task automatic finish_test(input string name);
    int waited = 0;
    while (pending_items() != 0 && waited < 64) begin
      tick();
      waited++;
    end
    for (int lane = 0; lane < num_lanes; lane++) begin
      if (read_q[lane].size() != 0) begin
        report_problem($sformatf("Lane %0d never delivered %0d read responses",
                                 lane, read_q[lane].size()));
      end
      if (ack_q[lane].size() != 0) begin
        report_problem($sformatf("Lane %0d never delivered %0d acks", lane, ack_q[lane].size()));
      end
      read_q[lane].delete();
      ack_q[lane].delete();
    end
    test_count++;
    if (error_count != test_start_errors) failed_tests++;
    $display("Test %s finished with %0d errors", name, error_count - test_start_errors);
    test_start_errors = error_count;
  endtask

  // --------------------
  // Case file handling
  // --------------------
  task automatic load_cases();
    int    fd;
    int    code;
    string line;
    fd = $fopen("verification/response_fabric_cases.txt", "r");
    if (fd == 0) begin
      report_problem("Could not open verification/response_fabric_cases.txt");
    end else begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        if (code > 0 && line.len() > 1 && line.getc(0) != "#") case_lines.push_back(line);
      end
      $fclose(fd);
    end
  endtask

  task automatic run_reset_test();
    repeat (4) @(posedge ap_clk);
    #5;
    assert (response_valid == '0) else report_mismatch("response_valid", 0, response_valid);
    assert (read_full == 1'b0) else report_mismatch("read_full", 0, read_full);
    assert (ack_full == 1'b0) else report_mismatch("ack_full", 0, ack_full);
    assert (setup_busy == 1'b1) else report_mismatch("setup_busy", 1, setup_busy);
    areset_control = 1'b0;
    tick();
    assert (setup_busy == 1'b0) else report_mismatch("setup_busy", 0, setup_busy);
    assert (response_valid == '0) else report_mismatch("response_valid", 0, response_valid);
    assert (read_full == 1'b0) else report_mismatch("read_full", 0, read_full);
    assert (ack_full == 1'b0) else report_mismatch("ack_full", 0, ack_full);
    finish_test("reset");
  endtask

  task automatic run_command(input string line);
    string       cmd;
    string       name;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    int          fields;
    fields = $sscanf(line, "%s", cmd);
    case (cmd)
      "R": begin
        fields = $sscanf(line, "%s %h %h %h", cmd, a, b, c);
        if (fields == 4) begin
          send_read(a[num_lanes-1:0], b[tag_width-1:0], c);
        end else begin
          report_problem({"Malformed read command in the cases file: ", line});
        end
      end
      "A": begin
        fields = $sscanf(line, "%s %h %h %h", cmd, a, b, c);
        if (fields == 4) begin
          send_ack(a[num_lanes-1:0], b[tag_width-1:0], c[status_width-1:0]);
        end else begin
          report_problem({"Malformed ack command in the cases file: ", line});
        end
      end
      "Y": begin
        fields = $sscanf(line, "%s %h", cmd, a);
        if (fields == 2) begin
          response_ready = a[num_lanes-1:0];
        end else begin
          report_problem({"Malformed ready command in the cases file: ", line});
        end
      end
      "W": begin
        fields = $sscanf(line, "%s %d", cmd, a);
        if (fields == 2) begin
          repeat (a) tick();
        end else begin
          report_problem({"Malformed wait command in the cases file: ", line});
        end
      end
      "F": begin
        fields = $sscanf(line, "%s %h %h", cmd, a, b);
        if (fields == 3) begin
          assert (read_full == a[0]) else report_mismatch("read_full", a[0], read_full);
          assert (ack_full == b[0]) else report_mismatch("ack_full", b[0], ack_full);
        end else begin
          report_problem({"Malformed full check in the cases file: ", line});
        end
      end
      "E": begin
        fields = $sscanf(line, "%s %s", cmd, name);
        if (fields != 2) begin
          report_problem({"Test end without a name in the cases file: ", line});
          name = "unnamed";
        end
        finish_test(name);
      end
      default: report_problem({"Unknown command in the cases file: ", line});
    endcase
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    int total_errors;
    areset_control = 1'b1;
    read_valid     = 1'b0;
    read_mask      = '0;
    read_tag       = '0;
    read_data      = '0;
    ack_valid      = 1'b0;
    ack_mask       = '0;
    ack_tag        = '0;
    ack_status     = '0;
    response_ready = '1;
    load_cases();
    if (case_lines.size() == 0) begin
      report_problem("The cases file holds no commands");
    end else begin
      cycle_limit = 200 + 20 * case_lines.size();
      run_reset_test();
      foreach (case_lines[k]) begin
        run_command(case_lines[k]);
      end
    end
    total_errors = error_count + u_response_fabric_top.u_assert.assert_failures;
    $display("Tests %0d, failed tests %0d, check errors %0d, assertion failures %0d",
             test_count, failed_tests, error_count,
             u_response_fabric_top.u_assert.assert_failures);
    if (total_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== verification/response_fabric_assert.sv ====
// Concurrent checks on the response path; bound into every response_fabric_top instance
module response_fabric_assert
  import response_pkg::*;
(
  input logic       ap_clk,
  input logic       areset_control,
  input logic       read_valid,
  input logic       ack_valid,
  input logic       read_full,
  input logic       ack_full,
  input lane_mask_t response_ready,
  input lane_mask_t response_valid,
  input lane_mask_t read_take,
  input lane_mask_t ack_take
);

  int   assert_failures = 0;
  logic clock_seen = 1'b0;

  // Outputs are only defined after the first reset edge
  always @(posedge ap_clk) begin
    clock_seen <= 1'b1;
  end

  // --------------------
  // Properties
  // --------------------
  // Ready is sampled at the take, two edges before the output shows up
  assert property (@(posedge ap_clk) disable iff (areset_control)
    (response_valid & ~$past(response_ready, 2)) == '0)
    else begin
      $error("response_valid on a lane that was not ready when its head was taken");
      assert_failures++;
    end

  assert property (@(posedge ap_clk) disable iff (areset_control) read_valid |-> !read_full)
    else begin
      $error("read strobe arrived while read_full was high");
      assert_failures++;
    end

  assert property (@(posedge ap_clk) disable iff (areset_control) ack_valid |-> !ack_full)
    else begin
      $error("ack strobe arrived while ack_full was high");
      assert_failures++;
    end

  // Both distributors never own the same lane
  assert property (@(posedge ap_clk) disable iff (areset_control) (read_take & ack_take) == '0)
    else begin
      $error("read_take and ack_take overlap on a lane");
      assert_failures++;
    end

  assert property (@(posedge ap_clk) (areset_control && clock_seen) |->
    (response_valid == '0 && !read_full && !ack_full))
    else begin
      $error("an output was high during reset");
      assert_failures++;
    end

endmodule

bind response_fabric_top response_fabric_assert u_assert (.*);

// ==== source/response_fabric_top.sv ====
// Top of the response return path; read and ack distributors feeding one per-lane merger
module response_fabric_top
  import response_pkg::*;
(
  input  logic                    ap_clk,
  input  logic                    areset_control,
  input  logic                    read_valid,
  input  lane_mask_t              read_mask,
  input  logic [tag_width-1:0]    read_tag,
  input  logic [data_width-1:0]   read_data,
  input  logic                    ack_valid,
  input  lane_mask_t              ack_mask,
  input  logic [tag_width-1:0]    ack_tag,
  input  logic [status_width-1:0] ack_status,
  input  lane_mask_t              response_ready,
  output lane_mask_t              response_valid,
  output lane_mask_t              response_is_ack,
  output logic [tag_width-1:0]    response_tag    [num_lanes],
  output logic [data_width-1:0]   response_data   [num_lanes],
  output logic [status_width-1:0] response_status [num_lanes],
  output logic                    read_full,
  output logic                    ack_full,
  output logic                    setup_busy
);

  read_payload_t read_in_payload;
  ack_payload_t  ack_in_payload;
  read_payload_t read_out_payload;
  ack_payload_t  ack_out_payload;
  lane_mask_t    read_request;
  lane_mask_t    ack_request;
  lane_mask_t    read_take;
  lane_mask_t    ack_take;
  lane_mask_t    read_strobe;
  lane_mask_t    ack_strobe;

  assign read_in_payload = '{tag: read_tag, data: read_data};
  assign ack_in_payload  = '{tag: ack_tag, status: ack_status};

  // Busy through reset and the first cycle after it
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      setup_busy <= 1'b1;
    end else begin
      setup_busy <= 1'b0;
    end
  end

  // --------------------
  // Distributors
  // --------------------
  response_distributor #(
    .payload_t (read_payload_t),
    .depth     (read_fifo_depth)
  ) u_read_distributor (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .in_valid       (read_valid),
    .in_mask        (read_mask),
    .in_payload     (read_in_payload),
    .lane_request   (read_request),
    .lane_take      (read_take),
    .head_payload   (),
    .lane_strobe    (read_strobe),
    .out_payload    (read_out_payload),
    .full           (read_full)
  );

  response_distributor #(
    .payload_t (ack_payload_t),
    .depth     (ack_fifo_depth)
  ) u_ack_distributor (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .in_valid       (ack_valid),
    .in_mask        (ack_mask),
    .in_payload     (ack_in_payload),
    .lane_request   (ack_request),
    .lane_take      (ack_take),
    .head_payload   (),
    .lane_strobe    (ack_strobe),
    .out_payload    (ack_out_payload),
    .full           (ack_full)
  );

  // --------------------
  // Merger
  // --------------------
  response_merger u_merger (
    .ap_clk          (ap_clk),
    .areset_control  (areset_control),
    .read_request    (read_request),
    .ack_request     (ack_request),
    .read_take       (read_take),
    .ack_take        (ack_take),
    .read_strobe     (read_strobe),
    .ack_strobe      (ack_strobe),
    .read_payload    (read_out_payload),
    .ack_payload     (ack_out_payload),
    .response_ready  (response_ready),
    .response_valid  (response_valid),
    .response_is_ack (response_is_ack),
    .response_tag    (response_tag),
    .response_data   (response_data),
    .response_status (response_status)
  );

endmodule

// ==== source/response_merger.sv ====
// Per-lane merge of the read and ack distributors with one shared rotating priority
module response_merger
  import response_pkg::*;
(
  input  logic                    ap_clk,
  input  logic                    areset_control,
  input  lane_mask_t              read_request,
  input  lane_mask_t              ack_request,
  output lane_mask_t              read_take,
  output lane_mask_t              ack_take,
  input  lane_mask_t              read_strobe,
  input  lane_mask_t              ack_strobe,
  input  read_payload_t           read_payload,
  input  ack_payload_t            ack_payload,
  input  lane_mask_t              response_ready,
  output lane_mask_t              response_valid,
  output lane_mask_t              response_is_ack,
  output logic [tag_width-1:0]    response_tag    [num_lanes],
  output logic [data_width-1:0]   response_data   [num_lanes],
  output logic [status_width-1:0] response_status [num_lanes]
);

  logic ack_first;
  logic read_pop;
  logic ack_pop;

  // --------------------
  // Take masks
  // --------------------
  // Priority side gets all its ready lanes, the other side only the lanes left over
  always_comb begin
    if (ack_first) begin
      ack_take  = ack_request & response_ready;
      read_take = read_request & response_ready & ~ack_request;
    end else begin
      read_take = read_request & response_ready;
      ack_take  = ack_request & response_ready & ~read_request;
    end
  end

  assign read_pop = (|read_request) & (read_take == read_request);
  assign ack_pop  = (|ack_request) & (ack_take == ack_request);

  // Pointer moves on a priority pop or an idle priority side
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      ack_first <= 1'b0;
    end else if (ack_first) begin
      if (ack_pop || !(|ack_request)) begin
        ack_first <= 1'b0;
      end
    end else if (read_pop || !(|read_request)) begin
      ack_first <= 1'b1;
    end
  end

  // --------------------
  // Requestor outputs
  // --------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      response_valid  <= '0;
      response_is_ack <= '0;
    end else begin
      response_valid  <= read_strobe | ack_strobe;
      response_is_ack <= ack_strobe;
    end
  end

  // At most one strobe per lane, takes are exclusive
  always_ff @(posedge ap_clk) begin
    for (int i = 0; i < num_lanes; i++) begin
      if (ack_strobe[i]) begin
        response_tag[i]    <= ack_payload.tag;
        response_data[i]   <= '0;
        response_status[i] <= ack_payload.status;
      end else if (read_strobe[i]) begin
        response_tag[i]    <= read_payload.tag;
        response_data[i]   <= read_payload.data;
        response_status[i] <= '0;
      end
    end
  end

endmodule

// ==== source/response_distributor.sv ====
// One-to-N distributor; queues one response kind and hands its head to every lane in its mask
module response_distributor
  import response_pkg::*;
#(
  parameter type payload_t = read_payload_t,
  parameter int  depth     = read_fifo_depth
) (
  input  logic       ap_clk,
  input  logic       areset_control,
  input  logic       in_valid,
  input  lane_mask_t in_mask,
  input  payload_t   in_payload,
  output lane_mask_t lane_request,
  input  lane_mask_t lane_take,
  output payload_t   head_payload,
  output lane_mask_t lane_strobe,
  output payload_t   out_payload,
  output logic       full
);

  // Queue entry keeps the target mask next to the payload
  typedef struct packed {
    lane_mask_t mask;
    payload_t   payload;
  } entry_t;

  logic       in_valid_reg;
  lane_mask_t in_mask_reg;
  payload_t   in_payload_reg;
  entry_t     push_entry;
  entry_t     head_entry;
  logic       push;
  logic       pop;
  logic       fifo_empty;

  // --------------------
  // Input register
  // --------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      in_valid_reg <= 1'b0;
    end else begin
      in_valid_reg <= in_valid;
    end
  end

  always_ff @(posedge ap_clk) begin
    in_mask_reg    <= in_mask;
    in_payload_reg <= in_payload;
  end

  // Responses with no target lane are dropped
  assign push       = in_valid_reg & (|in_mask_reg);
  assign push_entry = '{mask: in_mask_reg, payload: in_payload_reg};

  // --------------------
  // Queue
  // --------------------
  response_fifo #(
    .payload_t (entry_t),
    .depth     (depth)
  ) u_fifo (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .write_en       (push),
    .write_data     (push_entry),
    .read_en        (pop),
    .read_data      (head_entry),
    .empty          (fifo_empty),
    .full           (full)
  );

  // --------------------
  // Head offer and pop
  // --------------------
  assign lane_request = fifo_empty ? '0 : head_entry.mask;
  assign head_payload = head_entry.payload;

  // Pop only when every target lane takes in the same cycle
  assign pop = ~fifo_empty & (lane_take == head_entry.mask);

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      lane_strobe <= '0;
    end else if (pop) begin
      lane_strobe <= head_entry.mask;
    end else begin
      lane_strobe <= '0;
    end
  end

  // Popped payload, qualified by lane_strobe
  always_ff @(posedge ap_clk) begin
    if (pop) begin
      out_payload <= head_entry.payload;
    end
  end

endmodule

// ==== source/response_fifo.sv ====
// Synchronous first-word-fall-through queue; one instance per distributor, payload set by type
module response_fifo #(
  parameter type payload_t = logic,
  parameter int  depth     = 16
) (
  input  logic     ap_clk,
  input  logic     areset_control,
  input  logic     write_en,
  input  payload_t write_data,
  input  logic     read_en,
  output payload_t read_data,
  output logic     empty,
  output logic     full
);

  // --------------------
  // Storage and pointers
  // --------------------
  payload_t                   storage [depth];
  logic [$clog2(depth)-1:0]   write_ptr;
  logic [$clog2(depth)-1:0]   read_ptr;
  logic [$clog2(depth+1)-1:0] count;
  logic                       do_write;
  logic                       do_read;

  assign empty = (count == '0);
  assign full  = (count == ($clog2(depth+1))'(depth));

  // Overflow and underflow requests are dropped here
  assign do_write = write_en & ~full;
  assign do_read  = read_en & ~empty;

  // Head is visible with no read latency
  assign read_data = storage[read_ptr];

  always_ff @(posedge ap_clk) begin
    if (do_write) begin
      storage[write_ptr] <= write_data;
    end
  end

  // --------------------
  // Pointer and fill count
  // --------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      write_ptr <= '0;
      read_ptr  <= '0;
      count     <= '0;
    end else begin
      if (do_write) begin
        if (write_ptr == ($clog2(depth))'(depth - 1)) begin
          write_ptr <= '0;
        end else begin
          write_ptr <= write_ptr + 1'b1;
        end
      end
      if (do_read) begin
        if (read_ptr == ($clog2(depth))'(depth - 1)) begin
          read_ptr <= '0;
        end else begin
          read_ptr <= read_ptr + 1'b1;
        end
      end
      case ({do_write, do_read})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== source/response_pkg.sv ====
// Lane count, queue depths, field widths and payload types of the response path; import by wildcard
package response_pkg;

  // --------------------
  // Sizing
  // --------------------

  // Requestor lanes served by one response path
  localparam int num_lanes = 4;

  // Queue depths per response kind
  localparam int read_fifo_depth = 16;
  localparam int ack_fifo_depth  = 8;

  // --------------------
  // Field widths
  // --------------------

  localparam int tag_width    = 8;
  localparam int data_width   = 32;
  localparam int status_width = 2;

  // --------------------
  // Types
  // --------------------

  // Target requestors, one bit per lane, several bits for a broadcast
  typedef logic [num_lanes-1:0] lane_mask_t;

  // Read response, tag and read data
  typedef struct packed {
    logic [tag_width-1:0]  tag;
    logic [data_width-1:0] data;
  } read_payload_t;

  // Write acknowledgement, tag and completion status
  typedef struct packed {
    logic [tag_width-1:0]    tag;
    logic [status_width-1:0] status;
  } ack_payload_t;

endpackage
